// ==== filelist.f ====
+incdir+include
design/track_feature_pkg.sv
design/track_score_pkg.sv
design/iou_divider.sv
design/feature_decode.sv
design/metric_execute.sv
design/score_result.sv
design/similarity_top.sv
tests/similarity_tb.sv

// ==== tests/similarity_tb.sv ====
/*
 * similarity score testbench
 * directed and random requests through the three stage pipe,
 * a reference model of iou, distances, penalty and weighted sum,
 * in-order compare of score and id, out_ready back-pressure
 */

`timescale 1ns/100ps
`include "track_defs.svh"

module similarity_tb import track_feature_pkg::*, track_score_pkg::*; ();

	localparam int N_IDENT  = 3;
	localparam int N_EDGE   = 4;
	localparam int N_RANDOM = 200;
	localparam int N_STALL  = 100;
	localparam int NUM_REQ  = N_IDENT + N_EDGE + N_RANDOM + N_STALL;

	logic               clk, reset_N;
	logic               in_valid, in_ready, out_valid, out_ready;
	box_t               cur_box;
	rgb_t               cur_color1, cur_color2;
	track_record_t      prev_record;
	weight_t            iou_weight, w_weight, h_weight;
	weight_t            color1_weight, color2_weight, hist_weight;
	score_t             score;
	logic [`ID_LEN-1:0] id;

	integer             seed;         // stimulus
	integer             ready_seed;   // out_ready pattern
	bit                 stall_mode;
	longint             exp_score_q[$];
	logic [`ID_LEN-1:0] exp_id_q[$];
	int                 sent, received;
	bit                 holding;      // out_valid seen without out_ready
	score_t             held_score;
	logic [`ID_LEN-1:0] held_id;
	longint             exp_s;
	logic [`ID_LEN-1:0] exp_i;

	similarity_top similarity_top_inst (
		.clk (clk), .reset_N (reset_N),
		.in_valid (in_valid), .in_ready (in_ready),
		.cur_box (cur_box), .cur_color1 (cur_color1), .cur_color2 (cur_color2),
		.prev_record (prev_record),
		.iou_weight (iou_weight), .w_weight (w_weight), .h_weight (h_weight),
		.color1_weight (color1_weight), .color2_weight (color2_weight),
		.hist_weight (hist_weight),
		.out_valid (out_valid), .out_ready (out_ready),
		.score (score), .id (id)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;   // 4 ns period
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic longint magnitude(input longint v);
		return (v < 0) ? -v : v;
	endfunction

	function automatic longint box_area(input box_t b);
		return longint'(b.x_br - b.x_tl) * longint'(b.y_br - b.y_tl);
	endfunction

	// sum of |a-b| over r, g, b
	function automatic longint rgb_l1(input rgb_t a, input rgb_t b);
		longint sum;
		sum = 0;
		for (int k = 0; k < 3; k++)
			sum += magnitude(longint'(a[k*`CHAN_LEN +: `CHAN_LEN]) -
				longint'(b[k*`CHAN_LEN +: `CHAN_LEN]));
		return sum;
	endfunction

	// floor(inter*1024/union) or 0 for an empty union
	function automatic longint overlap_iou(input box_t a, input box_t b);
		longint ix_tl, iy_tl, ix_br, iy_br, ow, oh, inter, uni;
		ix_tl = (a.x_tl > b.x_tl) ? a.x_tl : b.x_tl;
		iy_tl = (a.y_tl > b.y_tl) ? a.y_tl : b.y_tl;
		ix_br = (a.x_br < b.x_br) ? a.x_br : b.x_br;
		iy_br = (a.y_br < b.y_br) ? a.y_br : b.y_br;
		ow    = (ix_br > ix_tl) ? ix_br - ix_tl : 0;
		oh    = (iy_br > iy_tl) ? iy_br - iy_tl : 0;
		inter = ow * oh;
		uni   = box_area(a) + box_area(b) - inter;
		return (uni == 0) ? 0 : (inter * 1024) / uni;
	endfunction

	function automatic longint expected_score(input box_t cb, input rgb_t c1,
		input rgb_t c2, input track_record_t rec, input weight_t wi, input weight_t ww,
		input weight_t wh, input weight_t wc1, input weight_t wc2, input weight_t whist);
		longint dw, dh, pen, plain;
		dw    = magnitude(longint'(cb.x_br - cb.x_tl) -
			longint'(rec.box.x_br - rec.box.x_tl));
		dh    = magnitude(longint'(cb.y_br - cb.y_tl) -
			longint'(rec.box.y_br - rec.box.y_tl));
		pen   = longint'(1) << rec.miss_count;
		plain = ww * dw + wh * dh + wc1 * rgb_l1(c1, rec.color1) +
			wc2 * rgb_l1(c2, rec.color2) + whist * pen;
		return wi * overlap_iou(cb, rec.box) + plain * 1024;   // integer metrics to q.10
	endfunction

	task automatic check_value(input longint actual, input longint expected, input string what);
		if (actual != expected) begin
			$display("Fail at %0t ns: %s, got %0d, expected %0d", $time, what,
				actual, expected);
			$display("TEST FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	function automatic box_t box_of(input int x0, input int y0, input int x1, input int y1);
		box_t b;
		b.x_tl = x0;
		b.y_tl = y0;
		b.x_br = x1;
		b.y_br = y1;
		return b;
	endfunction

	task automatic random_box(output box_t b);
		logic [`COORD_LEN-1:0] a0, a1, b0, b1;
		a0 = 8'($random(seed));
		a1 = 8'($random(seed));
		b0 = 8'($random(seed));
		b1 = 8'($random(seed));
		b  = box_of((a0 < a1) ? a0 : a1, (b0 < b1) ? b0 : b1,
			(a0 < a1) ? a1 : a0, (b0 < b1) ? b1 : b0);   // br never left of tl
	endtask

	task automatic random_request(output box_t cb, output rgb_t c1, output rgb_t c2,
		output track_record_t rec);
		random_box(cb);
		random_box(rec.box);
		c1             = 24'($random(seed));
		c2             = 24'($random(seed));
		rec.color1     = 24'($random(seed));
		rec.color2     = 24'($random(seed));
		rec.id         = 8'($random(seed));
		rec.miss_count = 3'($random(seed));
	endtask

	task automatic random_weights();
		iou_weight    <= weight_t'($random(seed));
		w_weight      <= weight_t'($random(seed));
		h_weight      <= weight_t'($random(seed));
		color1_weight <= weight_t'($random(seed));
		color2_weight <= weight_t'($random(seed));
		hist_weight   <= weight_t'($random(seed));
		@(posedge clk);   // settle before the first request
	endtask

	// present one request and return after its transfer edge
	task automatic send_request(input box_t cb, input rgb_t c1, input rgb_t c2,
		input track_record_t rec, input longint want);
		in_valid    <= 1'b1;
		cur_box     <= cb;
		cur_color1  <= c1;
		cur_color2  <= c2;
		prev_record <= rec;
		@(posedge clk);
		while (!in_ready)
			@(posedge clk);
		exp_score_q.push_back(want);
		exp_id_q.push_back(rec.id);
		sent++;
	endtask

	task automatic wait_drain();
		in_valid <= 1'b0;
		while (received != sent)
			@(posedge clk);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		box_t          b;
		rgb_t          c1, c2;
		track_record_t r;
		int            gap;
		longint        want;
		seed          = 32'hd04c_471e;
		reset_N       = 1'b0;
		in_valid      = 1'b0;
		cur_box       = '0;
		cur_color1    = '0;
		cur_color2    = '0;
		prev_record   = '0;
		iou_weight    = '0;
		w_weight      = '0;
		h_weight      = '0;
		color1_weight = '0;
		color2_weight = '0;
		hist_weight   = '0;
		stall_mode    = 1'b0;
		sent          = 0;
		received      = 0;
		repeat (4) @(posedge clk);
		reset_N <= 1'b1;
		@(posedge clk);
		check_value(in_ready, 1, "in_ready after reset");
		check_value(out_valid, 0, "out_valid after reset");

		// identical objects with full overlap and no misses
		random_weights();
		for (int k = 0; k < N_IDENT; k++) begin
			random_request(b, c1, c2, r);
			if (box_area(b) == 0)
				b = box_of(3, 4, 40, 50);
			r.box        = b;
			r.color1     = c1;
			r.color2     = c2;
			r.miss_count = '0;
			// full iou plus a penalty of one
			want = longint'(iou_weight) * 1024 + longint'(hist_weight) * 1024;
			send_request(b, c1, c2, r, want);
		end

		// disjoint and zero-area boxes
		for (int k = 0; k < N_EDGE; k++) begin
			random_request(b, c1, c2, r);
			case (k)
				0: begin
					b     = box_of(10, 10, 40, 40);
					r.box = box_of(100, 100, 150, 120);
				end
				1: begin
					b     = box_of(20, 20, 20, 50);   // zero width so union is 0
					r.box = box_of(20, 20, 20, 50);
				end
				2: begin
					b     = box_of(5, 5, 5, 5);   // single point
					r.box = box_of(0, 0, 30, 30);
				end
				default: begin
					b     = box_of(0, 0, 60, 60);
					r.box = box_of(60, 0, 90, 60);   // touching edge
				end
			endcase
			// iou term left out, distances only
			want = expected_score(b, c1, c2, r, '0, w_weight, h_weight,
				color1_weight, color2_weight, hist_weight);
			send_request(b, c1, c2, r, want);
		end
		wait_drain();

		// back to back random
		random_weights();
		for (int k = 0; k < N_RANDOM; k++) begin
			random_request(b, c1, c2, r);
			want = expected_score(b, c1, c2, r, iou_weight, w_weight, h_weight,
				color1_weight, color2_weight, hist_weight);
			send_request(b, c1, c2, r, want);
		end
		wait_drain();

		// input gaps and output back-pressure
		random_weights();
		stall_mode = 1'b1;
		for (int k = 0; k < N_STALL; k++) begin
			random_request(b, c1, c2, r);
			want = expected_score(b, c1, c2, r, iou_weight, w_weight, h_weight,
				color1_weight, color2_weight, hist_weight);
			send_request(b, c1, c2, r, want);
			gap = $random(seed) & 3;
			if (gap != 0) begin
				in_valid <= 1'b0;
				repeat (gap) @(posedge clk);
			end
		end
		wait_drain();
		stall_mode = 1'b0;
		repeat (5) @(posedge clk);

		if (received == NUM_REQ && sent == NUM_REQ && exp_score_q.size() == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("request count wrong, sent %0d, received %0d of %0d",
				sent, received, NUM_REQ);
			$display("TEST FAILED");
			$fatal(1, "count mismatch");
		end
	end

	// out_ready with random low cycles when stalling
	initial begin
		ready_seed = 32'hd04c_471e;
		out_ready  = 1'b1;
		forever begin
			@(posedge clk);
			out_ready <= stall_mode ? (($random(ready_seed) & 3) != 0) : 1'b1;
		end
	end

	// ----------------------------------------
	// compare process
	// ----------------------------------------
	always @(posedge clk) begin
		if (reset_N && out_valid) begin
			if (holding) begin
				check_value(score, held_score, "score changed while waiting");
				check_value(id, held_id, "id changed while waiting");
			end
			if (out_ready) begin
				holding = 1'b0;
				if (exp_score_q.size() == 0) begin
					$display("result at %0t ns without a pending request", $time);
					$display("TEST FAILED");
					$fatal(1, "unexpected result");
				end else begin
					exp_s = exp_score_q.pop_front();
					exp_i = exp_id_q.pop_front();
					check_value(score, exp_s, "score");
					check_value(id, exp_i, "id");
					received++;
				end
			end else begin
				holding    = 1'b1;   // must stay put next cycle
				held_score = score;
				held_id    = id;
			end
		end
	end

	// watchdog
	initial begin
		repeat (NUM_REQ * 40 + 200) @(posedge clk);
		$display("watchdog expired, outputs stalled after %0d of %0d results",
			received, NUM_REQ);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

endmodule

// ==== design/similarity_top.sv ====
/*
 * similarity score top
 * decode -> execute -> result, valid/ready between stages,
 * up to three requests in flight, results in order
 */

`timescale 1ns/100ps
`include "track_defs.svh"

module similarity_top import track_feature_pkg::*, track_score_pkg::*; (
	input  logic               clk,
	input  logic               reset_N,
	input  logic               in_valid,
	output logic               in_ready,
	input  box_t               cur_box,
	input  rgb_t               cur_color1,
	input  rgb_t               cur_color2,
	input  track_record_t      prev_record,
	input  weight_t            iou_weight,
	input  weight_t            w_weight,
	input  weight_t            h_weight,
	input  weight_t            color1_weight,
	input  weight_t            color2_weight,
	input  weight_t            hist_weight,
	output logic               out_valid,
	input  logic               out_ready,
	output score_t             score,
	output logic [`ID_LEN-1:0] id
);

	// ----------------------------------------
	// decode -> execute
	// ----------------------------------------
	logic                  dec_valid, dec_ready;
	logic [`COORD_LEN-1:0] cur_w, cur_h, prev_w, prev_h;
	box_t                  prev_box, cur_box_q;
	rgb_t                  cur_color1_q, cur_color2_q, prev_color1, prev_color2;
	logic [`HIST_LEN-1:0]  miss_count;
	logic [`ID_LEN-1:0]    dec_id;

	// execute -> result
	logic                    exe_valid, exe_ready;
	iou_t                    iou;
	dist_t                   dw, dh, dc1, dc2;
	logic [`PENALTY_LEN-1:0] penalty;
	logic [`ID_LEN-1:0]      id_q;

	feature_decode feature_decode_inst (
		.clk (clk), .reset_N (reset_N),
		.in_valid (in_valid), .in_ready (in_ready),
		.cur_box (cur_box), .cur_color1 (cur_color1), .cur_color2 (cur_color2),
		.prev_record (prev_record),
		.dec_valid (dec_valid), .dec_ready (dec_ready),
		.cur_w (cur_w), .cur_h (cur_h), .prev_w (prev_w), .prev_h (prev_h),
		.prev_box (prev_box), .cur_box_q (cur_box_q),
		.cur_color1_q (cur_color1_q), .cur_color2_q (cur_color2_q),
		.prev_color1 (prev_color1), .prev_color2 (prev_color2),
		.miss_count (miss_count), .id (dec_id)
	);

	metric_execute metric_execute_inst (
		.clk (clk), .reset_N (reset_N),
		.dec_valid (dec_valid), .dec_ready (dec_ready),
		.cur_w (cur_w), .cur_h (cur_h), .prev_w (prev_w), .prev_h (prev_h),
		.prev_box (prev_box), .cur_box_q (cur_box_q),
		.cur_color1_q (cur_color1_q), .cur_color2_q (cur_color2_q),
		.prev_color1 (prev_color1), .prev_color2 (prev_color2),
		.miss_count (miss_count), .id (dec_id),
		.exe_valid (exe_valid), .exe_ready (exe_ready),
		.iou (iou), .dw (dw), .dh (dh), .dc1 (dc1), .dc2 (dc2),
		.penalty (penalty), .id_q (id_q)
	);

	score_result score_result_inst (
		.clk (clk), .reset_N (reset_N),
		.exe_valid (exe_valid), .exe_ready (exe_ready),
		.iou (iou), .dw (dw), .dh (dh), .dc1 (dc1), .dc2 (dc2),
		.penalty (penalty), .id_q (id_q),
		.iou_weight (iou_weight), .w_weight (w_weight), .h_weight (h_weight),
		.color1_weight (color1_weight), .color2_weight (color2_weight),
		.hist_weight (hist_weight),
		.out_valid (out_valid), .out_ready (out_ready),
		.score (score), .id (id)
	);

endmodule

// ==== design/score_result.sv ====
/*
 * score result stage
 * one weighted metric added per cycle over six cycles,
 * q22.10 score held with the id until out_ready
 */

`timescale 1ns/100ps
`include "track_defs.svh"

module score_result import track_score_pkg::*; (
	input  logic                    clk,
	input  logic                    reset_N,

	input  logic                    exe_valid,
	output logic                    exe_ready,
	input  iou_t                    iou,
	input  dist_t                   dw,
	input  dist_t                   dh,
	input  dist_t                   dc1,
	input  dist_t                   dc2,
	input  logic [`PENALTY_LEN-1:0] penalty,
	input  logic [`ID_LEN-1:0]      id_q,

	input  weight_t                 iou_weight,
	input  weight_t                 w_weight,
	input  weight_t                 h_weight,
	input  weight_t                 color1_weight,
	input  weight_t                 color2_weight,
	input  weight_t                 hist_weight,

	output logic                    out_valid,
	input  logic                    out_ready,
	output score_t                  score,
	output logic [`ID_LEN-1:0]      id
);

	typedef enum logic [1:0] {ST_IDLE, ST_ACC, ST_OUT} res_state_t;

	res_state_t              state;
	logic [2:0]              term;              // 0..5
	logic                    take_exe;
	iou_t                    iou_q;
	dist_t                   dw_q, dh_q, dc1_q, dc2_q;
	logic [`PENALTY_LEN-1:0] pen_q;
	weight_t                 sel_w;
	score_t                  sel_m;             // metric in q*.10

	assign exe_ready = (state == ST_IDLE);
	assign take_exe  = exe_valid && exe_ready;
	assign out_valid = (state == ST_OUT);

	// ----------------------------------------
	// term select, one multiplier
	// ----------------------------------------
	always_comb begin
		case (term)
			3'd0:    begin sel_w = iou_weight;    sel_m = score_t'(iou_q); end   // already q0.10
			3'd1:    begin sel_w = w_weight;      sel_m = score_t'(dw_q) << `FRAC_BITS; end
			3'd2:    begin sel_w = h_weight;      sel_m = score_t'(dh_q) << `FRAC_BITS; end
			3'd3:    begin sel_w = color1_weight; sel_m = score_t'(dc1_q) << `FRAC_BITS; end
			3'd4:    begin sel_w = color2_weight; sel_m = score_t'(dc2_q) << `FRAC_BITS; end
			default: begin sel_w = hist_weight;   sel_m = score_t'(pen_q) << `FRAC_BITS; end
		endcase
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= ST_IDLE;
			term  <= '0;
		end else begin
			case (state)
				ST_IDLE: if (take_exe) begin
					state <= ST_ACC;
					term  <= '0;
				end
				ST_ACC: begin
					term <= term + 1'b1;
					if (term == 3'(`TERM_CNT - 1)) state <= ST_OUT;   // last term in
				end
				ST_OUT:  if (out_ready) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// metric copies and running sum
	always_ff @(posedge clk) begin
		if (take_exe) begin
			iou_q <= iou;
			dw_q  <= dw;
			dh_q  <= dh;
			dc1_q <= dc1;
			dc2_q <= dc2;
			pen_q <= penalty;
			id    <= id_q;
			score <= '0;
		end else if (state == ST_ACC) begin
			score <= score + score_t'(sel_w) * sel_m;   // max sum fits 32 bits
		end
	end

endmodule

// ==== design/metric_execute.sv ====
/*
 * metric execute stage
 * l1 distances of size and colors, miss penalty,
 * intersection and union areas, then iou through the divider
 * latency varies with the divider, exe_valid marks the end
 */

`timescale 1ns/100ps
`include "track_defs.svh"

module metric_execute import track_feature_pkg::*, track_score_pkg::*; (
	input  logic                    clk,
	input  logic                    reset_N,

	input  logic                    dec_valid,
	output logic                    dec_ready,
	input  logic [`COORD_LEN-1:0]   cur_w,
	input  logic [`COORD_LEN-1:0]   cur_h,
	input  logic [`COORD_LEN-1:0]   prev_w,
	input  logic [`COORD_LEN-1:0]   prev_h,
	input  box_t                    prev_box,
	input  box_t                    cur_box_q,
	input  rgb_t                    cur_color1_q,
	input  rgb_t                    cur_color2_q,
	input  rgb_t                    prev_color1,
	input  rgb_t                    prev_color2,
	input  logic [`HIST_LEN-1:0]    miss_count,
	input  logic [`ID_LEN-1:0]      id,

	output logic                    exe_valid,
	input  logic                    exe_ready,
	output iou_t                    iou,
	output dist_t                   dw,
	output dist_t                   dh,
	output dist_t                   dc1,
	output dist_t                   dc2,
	output logic [`PENALTY_LEN-1:0] penalty,
	output logic [`ID_LEN-1:0]      id_q
);

	typedef enum logic [1:0] {ST_IDLE, ST_START, ST_RUN, ST_HOLD} exe_state_t;

	exe_state_t            state;
	logic                  take_dec;
	logic                  div_start, div_done;
	logic [`COORD_LEN-1:0] ix_tl, iy_tl, ix_br, iy_br;   // overlap rectangle
	logic [`COORD_LEN-1:0] ov_w, ov_h;
	logic [`AREA_LEN-1:0]  inter_now;
	logic [`AREA_LEN:0]    union_now;                     // one spare bit for a1+a2
	logic [`AREA_LEN-1:0]  inter_area, union_area;

	function automatic logic [`COORD_LEN-1:0] abs_diff(
		input logic [`COORD_LEN-1:0] a,
		input logic [`COORD_LEN-1:0] b);
		abs_diff = (a > b) ? (a - b) : (b - a);
	endfunction

	// channels are coordinate wide, sum of three
	function automatic dist_t rgb_dist(input rgb_t a, input rgb_t b);
		dist_t sum;
		sum = '0;
		for (int k = 0; k < 3; k++)
			sum = sum + dist_t'(abs_diff(a[k*`CHAN_LEN +: `CHAN_LEN],
				b[k*`CHAN_LEN +: `CHAN_LEN]));
		rgb_dist = sum;
	endfunction

	assign dec_ready = (state == ST_IDLE);
	assign take_dec  = dec_valid && dec_ready;
	assign div_start = (state == ST_START);   // one cycle after registering
	assign exe_valid = (state == ST_HOLD);

	// ----------------------------------------
	// overlap geometry
	// ----------------------------------------
	assign ix_tl = (cur_box_q.x_tl > prev_box.x_tl) ? cur_box_q.x_tl : prev_box.x_tl;
	assign iy_tl = (cur_box_q.y_tl > prev_box.y_tl) ? cur_box_q.y_tl : prev_box.y_tl;
	assign ix_br = (cur_box_q.x_br < prev_box.x_br) ? cur_box_q.x_br : prev_box.x_br;
	assign iy_br = (cur_box_q.y_br < prev_box.y_br) ? cur_box_q.y_br : prev_box.y_br;
	assign ov_w  = (ix_br > ix_tl) ? ix_br - ix_tl : '0;   // no overlap -> 0
	assign ov_h  = (iy_br > iy_tl) ? iy_br - iy_tl : '0;
	assign inter_now = ov_w * ov_h;
	// union stays inside the 256x256 frame, top bit drops
	assign union_now = (cur_w * cur_h) + (prev_w * prev_h) - inter_now;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:  if (take_dec) state <= ST_START;
				ST_START: state <= ST_RUN;
				ST_RUN:   if (div_done) state <= ST_HOLD;   // iou now stable
				ST_HOLD:  if (exe_ready) state <= ST_IDLE;
				default:  state <= ST_IDLE;
			endcase
		end
	end

	// metrics, held until the item leaves
	always_ff @(posedge clk) begin
		if (take_dec) begin
			dw         <= dist_t'(abs_diff(cur_w, prev_w));
			dh         <= dist_t'(abs_diff(cur_h, prev_h));
			dc1        <= rgb_dist(cur_color1_q, prev_color1);
			dc2        <= rgb_dist(cur_color2_q, prev_color2);
			penalty    <= `PENALTY_LEN'(1) << miss_count;
			id_q       <= id;
			inter_area <= inter_now;
			union_area <= union_now[`AREA_LEN-1:0];
		end
	end

	// quotient register holds until the next start
	iou_divider iou_divider_inst (
		.clk        (clk),
		.reset_N    (reset_N),
		.start      (div_start),
		.inter_area (inter_area),
		.union_area (union_area),
		.done       (div_done),
		.iou        (iou)
	);

endmodule

// ==== design/feature_decode.sv ====
/*
 * feature decode stage
 * takes a request, unpacks the history record and
 * derives box widths and heights from the corners
 * one item held, output registered
 */

`timescale 1ns/100ps
`include "track_defs.svh"

module feature_decode import track_feature_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_N,

	input  logic                  in_valid,
	output logic                  in_ready,
	input  box_t                  cur_box,
	input  rgb_t                  cur_color1,
	input  rgb_t                  cur_color2,
	input  track_record_t         prev_record,

	output logic                  dec_valid,
	input  logic                  dec_ready,
	output logic [`COORD_LEN-1:0] cur_w,
	output logic [`COORD_LEN-1:0] cur_h,
	output logic [`COORD_LEN-1:0] prev_w,
	output logic [`COORD_LEN-1:0] prev_h,
	output box_t                  prev_box,
	output box_t                  cur_box_q,
	output rgb_t                  cur_color1_q,
	output rgb_t                  cur_color2_q,
	output rgb_t                  prev_color1,
	output rgb_t                  prev_color2,
	output logic [`HIST_LEN-1:0]  miss_count,
	output logic [`ID_LEN-1:0]    id
);

	logic take_in;   // request transfer this edge

	// empty, or the held item leaves this edge
	assign in_ready = !dec_valid || dec_ready;
	assign take_in  = in_valid && in_ready;

	// ----------------------------------------
	// occupancy
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			dec_valid <= 1'b0;
		end else if (take_in) begin
			dec_valid <= 1'b1;
		end else if (dec_ready) begin
			dec_valid <= 1'b0;   // taken, nothing new
		end
	end

	// ----------------------------------------
	// item registers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (take_in) begin
			cur_box_q    <= cur_box;
			cur_color1_q <= cur_color1;
			cur_color2_q <= cur_color2;
			// split the record
			id           <= prev_record.id;
			miss_count   <= prev_record.miss_count;
			prev_box     <= prev_record.box;
			prev_color1  <= prev_record.color1;
			prev_color2  <= prev_record.color2;
			// sizes from corners, br never left of tl
			cur_w        <= cur_box.x_br - cur_box.x_tl;
			cur_h        <= cur_box.y_br - cur_box.y_tl;
			prev_w       <= prev_record.box.x_br - prev_record.box.x_tl;
			prev_h       <= prev_record.box.y_br - prev_record.box.y_tl;
		end
	end

endmodule

// ==== design/iou_divider.sv ====
/*
 * iou divider
 * restoring shift-and-subtract, floor(inter * 1024 / union)
 * one quotient bit per cycle, msb first, 11 cycles
 * zero union answers zero after one cycle
 */

`timescale 1ns/100ps
`include "track_defs.svh"

module iou_divider import track_score_pkg::*; (
	input  logic                 clk,
	input  logic                 reset_N,
	input  logic                 start,
	input  logic [`AREA_LEN-1:0] inter_area,
	input  logic [`AREA_LEN-1:0] union_area,
	output logic                 done,
	output iou_t                 iou
);

	localparam int STEP_W = $clog2(`DIV_STEPS);

	logic                 busy;
	logic                 load;       // accepted start
	logic [STEP_W-1:0]    step;
	logic [`AREA_LEN:0]   rem;        // partial remainder, < 2*divisor
	logic [`AREA_LEN-1:0] divisor;
	logic                 q_bit;
	logic [`AREA_LEN:0]   rem_next;

	assign load = start && !busy;

	// ----------------------------------------
	// one restoring step
	// ----------------------------------------
	assign q_bit    = (rem >= {1'b0, divisor});
	assign rem_next = q_bit ? rem - {1'b0, divisor} : rem;   // restore on 0

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy <= 1'b0;
			step <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;   // pulse
			if (load) begin
				step <= '0;
				if (union_area == '0)
					done <= 1'b1;   // nothing to divide
				else
					busy <= 1'b1;
			end else if (busy) begin
				step <= step + 1'b1;
				if (step == STEP_W'(`DIV_STEPS - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// first step compares inter itself, inter <= union so the
	// integer bit is 1 only on full overlap
	always_ff @(posedge clk) begin
		if (load) begin
			rem     <= {1'b0, inter_area};
			divisor <= union_area;
			iou     <= '0;
		end else if (busy) begin
			rem <= {rem_next[`AREA_LEN-1:0], 1'b0};   // next fraction bit
			iou <= {iou[`IOU_LEN-2:0], q_bit};
		end
	end

endmodule

// ==== design/track_score_pkg.sv ====
/*
 * track score types
 * iou fraction, l1 distance, weight and the final score
 */

`include "track_defs.svh"

package track_score_pkg;

	// q0.10, 0..1024
	typedef logic [`IOU_LEN-1:0] iou_t;

	// plain integer distance, shifted into q*.10 when weighted
	typedef logic [`DIST_LEN-1:0] dist_t;

	// unsigned static weight
	typedef logic [`WEIGHT_LEN-1:0] weight_t;

	// weighted sum, q22.10
	typedef logic [`SCORE_LEN-1:0] score_t;

endpackage

// ==== design/track_feature_pkg.sv ====
/*
 * track feature types
 * bounding box corners, rgb signature and the packed
 * history record of one previously seen object
 */

`include "track_defs.svh"

package track_feature_pkg;

	// four corners, x_tl in the top byte
	typedef struct packed {
		logic [`COORD_LEN-1:0] x_tl;
		logic [`COORD_LEN-1:0] y_tl;
		logic [`COORD_LEN-1:0] x_br;   // x_br >= x_tl
		logic [`COORD_LEN-1:0] y_br;   // y_br >= y_tl
	} box_t;                           // 32 bits

	// r in [7:0], g in [15:8], b in [23:16]
	typedef logic [`COLOR_LEN-1:0] rgb_t;

	// ----------------------------------------
	// history record, one memory line
	// ----------------------------------------
	typedef struct packed {
		logic [`ID_LEN-1:0]   id;          // msb side
		logic [`HIST_LEN-1:0] miss_count;  // frames since last seen
		box_t                 box;
		rgb_t                 color1;
		rgb_t                 color2;      // lsb side
	} track_record_t;                      // 91 bits

endpackage

// ==== include/track_defs.svh ====
/*
 * tracker similarity field widths
 * box, color, id and history sizes, fixed-point fraction,
 * divider step count and score term count
 */

`ifndef TRACK_DEFS_SVH
`define TRACK_DEFS_SVH

// ----------------------------------------
// feature fields
// ----------------------------------------
`define COORD_LEN    8     // one box corner coordinate
`define CHAN_LEN     8     // one color channel, red in the low byte
`define COLOR_LEN    24    // rgb signature, three channels
`define ID_LEN       8     // object id
`define HIST_LEN     3     // frame-miss count
`define AREA_LEN     16    // w*h of a box, also the union

// ----------------------------------------
// metrics and score
// ----------------------------------------
`define FRAC_BITS    10                // fraction bits, q*.10
`define IOU_LEN      (`FRAC_BITS + 1)  // 1024 means full overlap
`define DIST_LEN     10                // up to 3*255 = 765
`define PENALTY_LEN  14                // 1 << miss count
`define WEIGHT_LEN   8
`define SCORE_LEN    32                // q22.10

// one quotient bit per step
`define DIV_STEPS    11
// weighted terms summed per request
`define TERM_CNT     6

`endif
